// File: source/procPkg.sv
/*
 * Processor definitions shared by every pipeline stage
 * Word widths, instruction field layout, opcodes, ALU codes and memory depths
 * Class and register-field helpers used by decode, hazard and writeback
 */
package procPkg;

    localparam int DATA_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int PC_W      = 8;   // Word address into imem
    localparam int DADDR_W   = 8;   // Word address into dmem

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    typedef logic [DATA_W-1:0]    wordT;
    typedef logic [REG_IDX_W-1:0] regIdxT;
    typedef logic [PC_W-1:0]      pcT;
    typedef logic [DADDR_W-1:0]   dAddrT;

    // Instruction fields
    localparam int OPC_HI   = 31;
    localparam int OPC_LO   = 27;
    localparam int RD_HI    = 26;
    localparam int RD_LO    = 22;
    localparam int RS_HI    = 21;
    localparam int RS_LO    = 17;
    localparam int RT_HI    = 16;
    localparam int RT_LO    = 12;
    localparam int SHAMT_HI = 11;
    localparam int SHAMT_LO = 7;
    localparam int ALUOP_HI = 6;
    localparam int ALUOP_LO = 2;
    localparam int IMM_HI   = 16;   // 17-bit signed immediate
    localparam int IMM_LO   = 0;

    localparam wordT NOP_WORD = '0; // add r0, r0, r0

    typedef enum logic [4:0] {
        OP_ALU  = 5'b00000,
        OP_ADDI = 5'b00101,
        OP_SW   = 5'b00111,
        OP_LW   = 5'b01000
    } opcodeT;

    typedef enum logic [4:0] {
        ADD = 5'd0,     // Must stay zero so the NOP is an add
        SUB = 5'd1,
        AND = 5'd2,
        OR  = 5'd3,
        SLL = 5'd4,
        SRA = 5'd5
    } aluOpT;

    typedef enum logic [1:0] {CLS_R, CLS_I, CLS_STORE, CLS_LOAD} insClassT;

    typedef enum logic [1:0] {BYP_REG, BYP_MEM, BYP_WB} bypSelT;

    function automatic insClassT insClass(wordT ir);
        insClassT cls;
        case (opcodeT'(ir[OPC_HI:OPC_LO]))
            OP_ALU:  cls = CLS_R;
            OP_ADDI: cls = CLS_I;
            OP_SW:   cls = CLS_STORE;
            OP_LW:   cls = CLS_LOAD;
            default: cls = CLS_R;   // Unknown opcodes act as ALU ops
        endcase
        return cls;
    endfunction

    function automatic regIdxT rsOf(wordT ir);
        return ir[RS_HI:RS_LO];
    endfunction

    function automatic regIdxT rdOf(wordT ir);
        return ir[RD_HI:RD_LO];
    endfunction

    // Register written by ir, zero if none
    function automatic regIdxT destReg(wordT ir);
        return (insClass(ir) == CLS_STORE) ? '0 : ir[RD_HI:RD_LO];
    endfunction

    // Second source, rt for R type and rd (store data) for stores
    function automatic regIdxT srcRegB(wordT ir);
        regIdxT src;
        case (insClass(ir))
            CLS_R:     src = ir[RT_HI:RT_LO];
            CLS_STORE: src = ir[RD_HI:RD_LO];
            default:   src = '0;
        endcase
        return src;
    endfunction

    function automatic wordT immExt(wordT ir);
        return {{(DATA_W-IMM_HI-1){ir[IMM_HI]}}, ir[IMM_HI:IMM_LO]};
    endfunction

endpackage

// File: source/stageIf.sv
/*
 * Pipeline stage bundle
 * Valid bit, instruction and two operands passed from one latch to the next
 * Execute/memory use: opA is the ALU result, opB the store data
 */
`timescale 1ns/1ps

interface stageIf;
    import procPkg::*;

    logic valid;    // Stage holds a real instruction
    wordT ir;       // Instruction word
    wordT opA;
    wordT opB;

    // Latch owner
    modport src (
        output valid,
        output ir,
        output opA,
        output opB
    );

    // Next stage
    modport dst (
        input valid,
        input ir,
        input opA,
        input opB
    );

endinterface

// File: source/fetchDecode.sv
/*
 * Fetch and decode stages
 * PC and imem address, fetch/decode latch, register index decode
 * and the decode/execute latch with bubble insertion on interlock
 */
`timescale 1ns/1ps

module fetchDecode (
    input  logic            clock,
    input  logic            rstN,
    input  logic            runEn,
    input  logic            stall,
    input  logic            freeze,
    output procPkg::pcT     imemAddr,
    input  procPkg::wordT   imemData,
    output procPkg::regIdxT readRegA,
    output procPkg::regIdxT readRegB,
    input  procPkg::wordT   readDataA,
    input  procPkg::wordT   readDataB,
    output procPkg::wordT   decodeIr,
    stageIf.src             dx
);
    import procPkg::*;

    pcT   pc;
    logic fdValid;
    wordT fdIr;
    logic advance;      // Fetch side may move

    assign advance  = !stall && !freeze;
    assign imemAddr = pc;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc      <= '0;
            fdValid <= 1'b0;
        end else if (advance) begin
            if (runEn)
                pc <= pc + 1'b1;    // Wraps at end of imem
            fdValid <= runEn;       // No fetch while stopped
        end
    end

    always_ff @(posedge clock) begin
        if (advance)
            fdIr <= imemData;
    end

    // Empty slot decodes as NOP so it never matches a hazard
    assign decodeIr = fdValid ? fdIr : NOP_WORD;
    assign readRegA = rsOf(decodeIr);
    assign readRegB = srcRegB(decodeIr);    // rt, store rd, or r0

    always_ff @(posedge clock) begin
        if (!rstN)
            dx.valid <= 1'b0;
        else if (!freeze)
            dx.valid <= fdValid && !stall;  // Bubble on interlock
    end

    always_ff @(posedge clock) begin
        if (!freeze) begin
            dx.ir  <= stall ? NOP_WORD : decodeIr;
            dx.opA <= readDataA;
            dx.opB <= readDataB;
        end
    end

endmodule

// File: source/hazardUnit.sv
/*
 * Hazard detection
 * Load-use interlock against the decode stage, operand bypass selection
 * for execute and store-data forwarding for the memory stage
 */
`timescale 1ns/1ps

module hazardUnit (
    input  procPkg::wordT   decodeIr,
    input  procPkg::wordT   executeIr,
    input  procPkg::wordT   memoryIr,
    input  procPkg::wordT   writebackIr,
    input  logic            executeValid,
    input  logic            memoryValid,
    input  logic            writebackValid,
    output logic            stall,
    output procPkg::bypSelT bypA,
    output procPkg::bypSelT bypB,
    output logic            storeBypass
);
    import procPkg::*;

    regIdxT decSrcA, decSrcB;
    regIdxT exeSrcA, exeSrcB;
    regIdxT exeDest, memDest, wbDest;   // Zero when slot empty or no write

    // Youngest producer wins, r0 never forwards
    function automatic bypSelT pickByp(regIdxT src, regIdxT memD, regIdxT wbD);
        bypSelT sel;
        if (src != '0 && src == memD)
            sel = BYP_MEM;
        else if (src != '0 && src == wbD)
            sel = BYP_WB;
        else
            sel = BYP_REG;
        return sel;
    endfunction

    assign decSrcA = rsOf(decodeIr);
    assign decSrcB = srcRegB(decodeIr);

    assign exeSrcA = executeValid ? rsOf(executeIr) : '0;
    assign exeSrcB = executeValid ? srcRegB(executeIr) : '0;

    assign exeDest = executeValid ? destReg(executeIr) : '0;
    assign memDest = memoryValid ? destReg(memoryIr) : '0;
    assign wbDest  = writebackValid ? destReg(writebackIr) : '0;

    // Load result not ready until writeback, hold decode one cycle
    assign stall = (insClass(executeIr) == CLS_LOAD) && exeDest != '0
                   && (exeDest == decSrcA || exeDest == decSrcB);

    assign bypA = pickByp(exeSrcA, memDest, wbDest);
    assign bypB = pickByp(exeSrcB, memDest, wbDest);

    // Store data in memory stage produced by the writeback instruction
    assign storeBypass = memoryValid && (insClass(memoryIr) == CLS_STORE)
                         && wbDest != '0 && wbDest == rdOf(memoryIr);

endmodule

// File: source/executeStage.sv
/*
 * Execute stage
 * Operand bypass muxes, immediate select, ALU and the execute/memory latch
 * Latch holds while the memory stage waits on the store port
 */
`timescale 1ns/1ps

module executeStage (
    input  logic            clock,
    input  logic            rstN,
    input  logic            freeze,
    stageIf.dst             dx,
    input  procPkg::bypSelT bypA,
    input  procPkg::bypSelT bypB,
    input  procPkg::wordT   memResult,
    input  procPkg::wordT   wbData,
    stageIf.src             xm
);
    import procPkg::*;

    wordT     opA;      // Bypassed register operands
    wordT     opB;
    wordT     aluB;
    wordT     imm;
    wordT     result;
    insClassT cls;
    aluOpT    aluOp;
    logic [SHAMT_HI-SHAMT_LO:0] shamt;

    function automatic wordT selOperand(bypSelT sel, wordT regVal, wordT memVal,
                                        wordT wbVal);
        wordT val;
        case (sel)
            BYP_MEM: val = memVal;
            BYP_WB:  val = wbVal;
            default: val = regVal;
        endcase
        return val;
    endfunction

    assign opA = selOperand(bypA, dx.opA, memResult, wbData);
    assign opB = selOperand(bypB, dx.opB, memResult, wbData);  // Store data too

    assign cls   = insClass(dx.ir);
    assign imm   = immExt(dx.ir);
    assign shamt = dx.ir[SHAMT_HI:SHAMT_LO];

    // Only R type carries an ALU code, the rest add
    assign aluOp = (cls == CLS_R) ? aluOpT'(dx.ir[ALUOP_HI:ALUOP_LO]) : ADD;
    assign aluB  = (cls == CLS_R) ? opB : imm;

    always_comb begin
        case (aluOp)
            ADD:     result = opA + aluB;
            SUB:     result = opA - aluB;
            AND:     result = opA & aluB;
            OR:      result = opA | aluB;
            SLL:     result = opA << shamt;
            SRA:     result = wordT'($signed(opA) >>> shamt);
            default: result = opA + aluB;   // Undefined codes behave as add
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN)
            xm.valid <= 1'b0;
        else if (!freeze)
            xm.valid <= dx.valid;
    end

    always_ff @(posedge clock) begin
        if (!freeze) begin
            xm.ir  <= dx.ir;
            xm.opA <= result;   // Also the dmem address
            xm.opB <= opB;
        end
    end

endmodule

// File: source/memWriteback.sv
/*
 * Memory and writeback stages
 * Data memory, store port handshake with pipeline freeze,
 * memory/writeback latch and register file write
 */
`timescale 1ns/1ps

module memWriteback (
    input  logic            clock,
    input  logic            rstN,
    stageIf.dst             xm,
    input  logic            storeBypass,
    output logic            storeValid,
    input  logic            storeReady,
    output procPkg::dAddrT  storeAddr,
    output procPkg::wordT   storeData,
    output logic            freeze,
    output logic            regWe,
    output procPkg::regIdxT regWIdx,
    output procPkg::wordT   regWData,
    output procPkg::wordT   writebackIr,
    output logic            writebackValid
);
    import procPkg::*;

    wordT     dmem [DMEM_DEPTH];
    dAddrT    memAddr;
    wordT     loadData;
    wordT     wbResult;
    insClassT memCls;

    assign memCls  = insClass(xm.ir);
    assign memAddr = xm.opA[DADDR_W-1:0];  // Low bits of ALU result

    assign storeValid = xm.valid && (memCls == CLS_STORE);
    assign freeze     = storeValid && !storeReady;  // Whole pipe waits
    assign storeAddr  = memAddr;
    assign storeData  = storeBypass ? regWData : xm.opB;

    always_ff @(posedge clock) begin
        if (storeValid && storeReady)
            dmem[memAddr] <= storeData;
    end

    assign loadData = dmem[memAddr];

    always_ff @(posedge clock) begin
        if (!rstN)
            writebackValid <= 1'b0;
        else if (!freeze)
            writebackValid <= xm.valid;
    end

    always_ff @(posedge clock) begin
        if (!freeze) begin
            writebackIr <= xm.ir;
            wbResult    <= (memCls == CLS_LOAD) ? loadData : xm.opA;
        end
    end

    assign regWIdx  = destReg(writebackIr);     // Zero for stores
    assign regWData = wbResult;
    assign regWe    = writebackValid && regWIdx != '0;

endmodule

// File: source/regFile.sv
/*
 * Register file, 32 x 32 bits
 * Two combinational read ports with write-through, r0 reads zero
 */
`timescale 1ns/1ps

module regFile (
    input  logic            clock,
    input  logic            rstN,
    input  logic            we,
    input  procPkg::regIdxT wIdx,
    input  procPkg::regIdxT rIdxA,
    input  procPkg::regIdxT rIdxB,
    input  procPkg::wordT   wData,
    output procPkg::wordT   rDataA,
    output procPkg::wordT   rDataB
);
    import procPkg::*;

    wordT regs [2**REG_IDX_W];

    always_ff @(posedge clock) begin
        if (!rstN)
            regs <= '{default: '0};
        else if (we && wIdx != '0)
            regs[wIdx] <= wData;
    end

    // Same-cycle write visible to decode
    assign rDataA = (rIdxA == '0) ? '0 : (we && wIdx == rIdxA) ? wData : regs[rIdxA];
    assign rDataB = (rIdxB == '0) ? '0 : (we && wIdx == rIdxB) ? wData : regs[rIdxB];

endmodule

// File: source/processorTop.sv
/*
 * Five-stage pipelined processor top
 * Instruction memory with its program load port, register file,
 * hazard control and the three pipeline parts
 */
`timescale 1ns/1ps

module processorTop (
    input  logic           clock,
    input  logic           rstN,
    input  logic           runEn,
    input  logic           progValid,
    output logic           progReady,
    input  procPkg::pcT    progAddr,
    input  procPkg::wordT  progData,
    output logic           storeValid,
    input  logic           storeReady,
    output procPkg::dAddrT storeAddr,
    output procPkg::wordT  storeData
);
    import procPkg::*;

    wordT   imem [IMEM_DEPTH];
    pcT     imemAddr;
    wordT   imemData;
    wordT   decodeIr;
    wordT   writebackIr;
    logic   writebackValid;
    logic   stall;          // Load-use bubble
    logic   freeze;         // Store back-pressure
    logic   storeBypass;
    bypSelT bypA;
    bypSelT bypB;
    regIdxT readRegA;
    regIdxT readRegB;
    wordT   readDataA;
    wordT   readDataB;
    logic   regWe;
    regIdxT regWIdx;
    wordT   regWData;

    stageIf dxBus ();       // Decode/execute latch
    stageIf xmBus ();       // Execute/memory latch

    // Program load only while stopped
    assign progReady = !runEn;

    always_ff @(posedge clock) begin
        if (progValid && progReady)
            imem[progAddr] <= progData;
    end

    assign imemData = imem[imemAddr];   // Async read, same-cycle fetch

    fetchDecode u_fetchDecode (
        .clock     (clock),
        .rstN      (rstN),
        .runEn     (runEn),
        .stall     (stall),
        .freeze    (freeze),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .readRegA  (readRegA),
        .readRegB  (readRegB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .decodeIr  (decodeIr),
        .dx        (dxBus)
    );

    hazardUnit u_hazardUnit (
        .decodeIr       (decodeIr),
        .executeIr      (dxBus.ir),
        .memoryIr       (xmBus.ir),
        .writebackIr    (writebackIr),
        .executeValid   (dxBus.valid),
        .memoryValid    (xmBus.valid),
        .writebackValid (writebackValid),
        .stall          (stall),
        .bypA           (bypA),
        .bypB           (bypB),
        .storeBypass    (storeBypass)
    );

    executeStage u_executeStage (
        .clock     (clock),
        .rstN      (rstN),
        .freeze    (freeze),
        .dx        (dxBus),
        .bypA      (bypA),
        .bypB      (bypB),
        .memResult (xmBus.opA),
        .wbData    (regWData),
        .xm        (xmBus)
    );

    memWriteback u_memWriteback (
        .clock          (clock),
        .rstN           (rstN),
        .xm             (xmBus),
        .storeBypass    (storeBypass),
        .storeValid     (storeValid),
        .storeReady     (storeReady),
        .storeAddr      (storeAddr),
        .storeData      (storeData),
        .freeze         (freeze),
        .regWe          (regWe),
        .regWIdx        (regWIdx),
        .regWData       (regWData),
        .writebackIr    (writebackIr),
        .writebackValid (writebackValid)
    );

    regFile u_regFile (
        .clock  (clock),
        .rstN   (rstN),
        .we     (regWe),
        .wIdx   (regWIdx),
        .rIdxA  (readRegA),
        .rIdxB  (readRegB),
        .wData  (regWData),
        .rDataA (readDataA),
        .rDataB (readDataB)
    );

endmodule

// File: sim/processorChk.sv
/*
 * Protocol checks for the processor top
 * Store port hold under back-pressure, load port gating and reset state
 */
`timescale 1ns/1ps

module processorChk (
    input logic           clock,
    input logic           rstN,
    input logic           runEn,
    input logic           progReady,
    input logic           storeValid,
    input logic           storeReady,
    input procPkg::dAddrT storeAddr,
    input procPkg::wordT  storeData
);

    int failCount = 0;  // Assertion failures so far

    // Stalled store keeps its address and data
    storeHold: assert property (@(posedge clock) disable iff (!rstN)
        storeValid && !storeReady |=> storeValid && $stable(storeAddr) && $stable(storeData))
        else begin
            failCount++;
            $error("store port changed while storeReady was low");
        end

    // Load port closed while running
    progGate: assert property (@(posedge clock) runEn |-> !progReady)
        else begin
            failCount++;
            $error("progReady high while runEn is high");
        end

    storeAfterReset: assert property (@(posedge clock) !rstN |=> !storeValid)
        else begin
            failCount++;
            $error("storeValid high in the cycle after reset");   // Valid bits cleared
        end

endmodule

bind processorTop processorChk u_processorChk (
    .clock      (clock),
    .rstN       (rstN),
    .runEn      (runEn),
    .progReady  (progReady),
    .storeValid (storeValid),
    .storeReady (storeReady),
    .storeAddr  (storeAddr),
    .storeData  (storeData)
);

// File: sim/tbProcessor.sv
/*
 * Testbench for the pipelined processor
 * Loads directed and random programs, runs them against a sequential
 * reference model and compares every store handshake in order
 */
`timescale 1ns/1ps

module tbProcessor;
    import procPkg::*;

    logic  clock;
    logic  rstN;
    logic  runEn;
    logic  progValid;
    logic  progReady;
    pcT    progAddr;
    wordT  progData;
    logic  storeValid;
    logic  storeReady = 1'b1;
    dAddrT storeAddr;
    wordT  storeData;

    wordT  prog[$];         // Program under construction
    wordT  progMem[$];      // All programs back to back
    int    progStart[$];
    int    progLen[$];      // Includes NOP padding
    string progName[$];
    bit    progRand[$];     // Random back-pressure for this test

    wordT  mRegs [32];      // Reference model state
    wordT  mMem [256];
    dAddrT expAddr[$];
    wordT  expData[$];

    string curName;
    bit    readyRandom;
    int    mismatches;
    int    otherErrors;
    int    storesChecked;

    processorTop u_processorTop (
        .clock      (clock),
        .rstN       (rstN),
        .runEn      (runEn),
        .progValid  (progValid),
        .progReady  (progReady),
        .progAddr   (progAddr),
        .progData   (progData),
        .storeValid (storeValid),
        .storeReady (storeReady),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic wordT encR(aluOpT fn, int rd, int rs, int rt, int sh);
        wordT w;
        w = '0;
        w[OPC_HI:OPC_LO]     = OP_ALU;
        w[RD_HI:RD_LO]       = 5'(rd);
        w[RS_HI:RS_LO]       = 5'(rs);
        w[RT_HI:RT_LO]       = 5'(rt);
        w[SHAMT_HI:SHAMT_LO] = 5'(sh);
        w[ALUOP_HI:ALUOP_LO] = fn;
        return w;
    endfunction

    // ADDI, SW and LW share one layout with the SW data register in rd
    function automatic wordT encI(opcodeT opc, int rd, int rs, int imm);
        wordT w;
        w = '0;
        w[OPC_HI:OPC_LO] = opc;
        w[RD_HI:RD_LO]   = 5'(rd);
        w[RS_HI:RS_LO]   = 5'(rs);
        w[IMM_HI:IMM_LO] = 17'(imm);
        return w;
    endfunction

    function automatic void emit(wordT w);
        prog.push_back(w);
    endfunction

    function automatic void modelReset();
        foreach (mRegs[i]) mRegs[i] = '0;
        foreach (mMem[i]) mMem[i] = '0;
    endfunction

    // Runs one instruction in program order and returns 1 for a store
    function automatic bit modelStep(wordT ins, output dAddrT addr, output wordT data);
        logic [4:0] opc, rd, rs, rt, sh, fn;
        wordT       a, b, imm, sum, res;
        bit         isStore;
        opc = ins[31:27];
        rd  = ins[26:22];
        rs  = ins[21:17];
        rt  = ins[16:12];
        sh  = ins[11:7];
        fn  = ins[6:2];
        imm = {{15{ins[16]}}, ins[16:0]};   // 17-bit signed immediate
        a   = mRegs[rs];
        b   = mRegs[rt];
        sum = a + imm;
        addr    = sum[7:0];                 // Low bits give the word address
        data    = mRegs[rd];
        isStore = 1'b0;
        case (opc)
            OP_ADDI: res = sum;
            OP_SW: begin
                res     = '0;
                isStore = 1'b1;
                mMem[addr] = data;
            end
            OP_LW: res = mMem[addr];
            default: begin
                case (fn)
                    5'd1:    res = a - b;
                    5'd2:    res = a & b;
                    5'd3:    res = a | b;
                    5'd4:    res = a << sh;
                    5'd5:    res = $signed(a) >>> sh;
                    default: res = a + b;
                endcase
            end
        endcase
        if (!isStore && rd != 5'd0)
            mRegs[rd] = res;                // r0 never changes
        return isStore;
    endfunction

    // Expected store list for one loaded program
    function automatic int refStores(int first, int n);
        dAddrT addr;
        wordT  data;
        modelReset();
        expAddr.delete();
        expData.delete();
        for (int i = 0; i < n; i++) begin
            if (modelStep(progMem[first + i], addr, data)) begin
                expAddr.push_back(addr);
                expData.push_back(data);
            end
        end
        return expAddr.size();
    endfunction

    function automatic void finishProgram(string name, bit rnd);
        progStart.push_back(progMem.size());
        progLen.push_back(prog.size() + 10);    // Trailing NOPs cover the drain
        progName.push_back(name);
        progRand.push_back(rnd);
        foreach (prog[i]) progMem.push_back(prog[i]);
        repeat (10) progMem.push_back(NOP_WORD);
        prog.delete();
    endfunction

    // Random mix where loads only hit addresses stored earlier
    function automatic void genRandom(int n);
        dAddrT stored[$];
        dAddrT addr;
        wordT  data;
        wordT  ins;
        int    kind, rd, rs, rt, off;
        modelReset();
        for (int i = 0; i < n; i++) begin
            kind = $urandom_range(0, 9);
            rd   = $urandom_range(0, 7);    // Few registers for dense dependences
            rs   = $urandom_range(0, 7);
            rt   = $urandom_range(0, 7);
            if (kind < 4) begin
                ins = encR(aluOpT'(5'($urandom_range(0, 5))), rd, rs, rt,
                           $urandom_range(0, 31));
            end else if (kind < 6 || (kind >= 8 && stored.size() == 0)) begin
                ins = encI(OP_ADDI, rd, rs, $urandom_range(0, 131071));
            end else if (kind < 8) begin
                ins = encI(OP_SW, rd, rs, $urandom_range(0, 255));
            end else begin
                addr = stored[$urandom_range(0, stored.size() - 1)];
                off  = int'(addr) - int'(mRegs[rs][7:0]);
                ins  = encI(OP_LW, rd, rs, off);
            end
            if (modelStep(ins, addr, data))
                stored.push_back(addr);
            emit(ins);
        end
    endfunction

    function automatic void buildDirected();
        // R-type ops with each result stored
        emit(encI(OP_ADDI, 1, 0, 1234));
        emit(encI(OP_ADDI, 2, 0, -300));
        emit(encR(ADD, 3, 1, 2, 0));
        emit(encI(OP_SW, 3, 0, 0));
        emit(encR(SUB, 4, 1, 2, 0));
        emit(encI(OP_SW, 4, 0, 1));
        emit(encR(AND, 5, 1, 2, 0));
        emit(encI(OP_SW, 5, 0, 2));
        emit(encR(OR, 6, 1, 2, 0));
        emit(encI(OP_SW, 6, 0, 3));
        emit(encR(SLL, 7, 1, 0, 5));
        emit(encI(OP_SW, 7, 0, 4));
        emit(encR(SRA, 8, 2, 0, 3));
        emit(encI(OP_SW, 8, 0, 5));
        finishProgram("aluStraight", 1'b0);

        emit(encI(OP_ADDI, 1, 0, 7));
        emit(encI(OP_ADDI, 2, 1, 3));   // Memory-stage bypass
        emit(encR(ADD, 3, 2, 1, 0));    // One from memory, one from writeback
        emit(encR(ADD, 4, 1, 3, 0));
        emit(encI(OP_SW, 4, 0, 8));
        emit(encR(SLL, 5, 4, 0, 2));
        emit(encI(OP_SW, 5, 4, 0));     // Data bypassed while the base reads through
        emit(encR(OR, 6, 5, 2, 0));
        emit(encI(OP_ADDI, 7, 6, -1));
        emit(encI(OP_SW, 7, 0, 9));
        emit(encI(OP_SW, 6, 0, 10));
        finishProgram("bypassChain", 1'b0);

        emit(encI(OP_ADDI, 1, 0, 42));
        emit(encI(OP_SW, 1, 0, 20));
        emit(encI(OP_ADDI, 2, 0, 20));
        emit(encI(OP_LW, 3, 2, 0));
        emit(encR(ADD, 4, 3, 3, 0));    // Load-use bubble
        emit(encI(OP_SW, 4, 0, 21));
        emit(encI(OP_LW, 5, 0, 21));
        emit(encI(OP_SW, 5, 0, 22));    // Load feeds store data
        emit(encI(OP_ADDI, 6, 0, 5));
        emit(encI(OP_SW, 6, 0, 23));
        emit(encI(OP_LW, 7, 0, 23));
        emit(encI(OP_SW, 1, 7, 40));    // Load feeds store address
        emit(encI(OP_LW, 3, 0, 20));
        emit(encI(OP_SW, 3, 3, 0));     // Both from the load
        emit(encI(OP_LW, 8, 0, 42));
        emit(encR(SUB, 9, 8, 4, 0));
        emit(encI(OP_SW, 9, 0, 24));
        finishProgram("loadUse", 1'b0);

        emit(encI(OP_ADDI, 1, 0, 11));
        emit(encI(OP_SW, 1, 0, 60));
        emit(encI(OP_SW, 1, 0, 61));
        emit(encI(OP_ADDI, 2, 1, 100));
        emit(encI(OP_SW, 2, 0, 62));
        emit(encI(OP_SW, 2, 2, 0));
        emit(encI(OP_LW, 3, 0, 62));
        emit(encI(OP_SW, 3, 0, 63));
        emit(encR(ADD, 4, 3, 1, 0));
        emit(encI(OP_SW, 4, 0, 64));
        emit(encI(OP_SW, 4, 0, 65));
        emit(encI(OP_SW, 1, 0, 66));
        finishProgram("storeBackPressure", 1'b1);

        emit(encI(OP_ADDI, 0, 0, 77));
        emit(encI(OP_SW, 0, 0, 50));    // r0 not forwarded
        emit(encI(OP_ADDI, 1, 0, 9));
        emit(encI(OP_SW, 1, 0, 51));
        emit(encR(ADD, 0, 1, 1, 0));
        emit(encI(OP_SW, 0, 0, 52));
        emit(encI(OP_LW, 0, 0, 51));
        emit(encI(OP_SW, 0, 0, 53));
        emit(encR(OR, 2, 0, 1, 0));
        emit(encI(OP_SW, 2, 0, 54));
        finishProgram("regZero", 1'b0);
    endfunction

    task automatic loadWord(pcT addr, wordT data);
        progValid = 1'b1;
        progAddr  = addr;
        progData  = data;
        do @(posedge clock); while (!progReady);
        @(negedge clock);
    endtask

    task automatic runTest(int t);
        curName = progName[t];
        @(negedge clock);
        rstN      = 1'b0;
        runEn     = 1'b0;
        progValid = 1'b0;
        repeat (5) @(negedge clock);
        rstN = 1'b1;
        for (int i = 0; i < progLen[t]; i++)
            loadWord(pcT'(i), progMem[progStart[t] + i]);
        progValid = 1'b0;
        void'(refStores(progStart[t], progLen[t]));
        readyRandom = progRand[t];
        runEn       = 1'b1;
        while (expAddr.size() != 0)
            @(negedge clock);
        repeat (6) @(negedge clock);    // Catch repeated stores
        runEn = 1'b0;
    endtask

    function automatic void printCounts();
        $display("Stores checked %0d, mismatches %0d, other errors %0d, checker errors %0d",
                 storesChecked, mismatches, otherErrors,
                 u_processorTop.u_processorChk.failCount);
    endfunction

    task automatic watchdog(int limit);
        repeat (limit) @(posedge clock);
        otherErrors++;
        $display("Timeout after %0d cycles, expected stores never arrived", limit);
        printCounts();
        $display("Simulation failed");
        $finish;
    endtask

    // Back-pressure changes only on the falling edge
    always @(negedge clock)
        storeReady = readyRandom ? ($urandom_range(0, 9) < 6) : 1'b1;

    // Store comparison on each handshake
    always @(posedge clock) begin
        dAddrT eAddr;
        wordT  eData;
        if (rstN && storeValid && storeReady) begin
            assert (expAddr.size() != 0) else begin
                otherErrors++;
                $display("Unexpected store in %s at address %h with data %h",
                         curName, storeAddr, storeData);
            end
            if (expAddr.size() != 0) begin
                eAddr = expAddr.pop_front();
                eData = expData.pop_front();
                storesChecked++;
                assert (storeAddr == eAddr) else begin
                    mismatches++;
                    $display("MISMATCH %s storeAddr expected %h actual %h",
                             curName, eAddr, storeAddr);
                end
                assert (storeData == eData) else begin
                    mismatches++;
                    $display("MISMATCH %s storeData expected %h actual %h",
                             curName, eData, storeData);
                end
            end
        end
    end

    initial begin
        int limit;
        rstN          = 1'b0;
        runEn         = 1'b0;
        progValid     = 1'b0;
        progAddr      = '0;
        progData      = '0;
        readyRandom   = 1'b0;
        mismatches    = 0;
        otherErrors   = 0;
        storesChecked = 0;
        void'($urandom(32'h517fd00d));
        buildDirected();
        for (int t = 0; t < 10; t++) begin
            genRandom(40);
            finishProgram($sformatf("random%0d", t), 1'b1);
        end
        limit = 200;    // Reset and drain margin
        foreach (progLen[i]) limit += progLen[i] * 4;
        fork
            watchdog(limit);
        join_none
        foreach (progLen[i]) runTest(i);
        printCounts();
        if (mismatches == 0 && otherErrors == 0
            && u_processorTop.u_processorChk.failCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: files.f
source/procPkg.sv
source/stageIf.sv
source/fetchDecode.sv
source/hazardUnit.sv
source/executeStage.sv
source/memWriteback.sv
source/regFile.sv
source/processorTop.sv
sim/processorChk.sv
sim/tbProcessor.sv

// File: Makefile
# Verilator build, run and lint for the pipelined processor

VERILATOR  ?= verilator
TOP        ?= tbProcessor
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run FAILED, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
